/* design/cpu_pkg.sv */
// Widths, instruction field positions, opcode, addressing mode and shift enums, flag struct
`default_nettype none

package cpu_pkg;

  localparam int unsigned DATA_W   = 32;          // Data and register width
  localparam int unsigned REG_AW   = 4;           // Register address width
  localparam int unsigned NUM_REGS = 16;          // All general purpose

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // Data-processing instruction layout
  localparam int unsigned AM_MSB     = 26;        // Addressing mode
  localparam int unsigned AM_LSB     = 25;
  localparam int unsigned OPC_MSB    = 24;        // ALU opcode
  localparam int unsigned OPC_LSB    = 21;
  localparam int unsigned S_BIT      = 20;        // Set condition codes
  localparam int unsigned RN_MSB     = 19;        // First source register
  localparam int unsigned RN_LSB     = 16;
  localparam int unsigned RD_MSB     = 15;        // Destination register
  localparam int unsigned RD_LSB     = 12;
  localparam int unsigned OP2_MSB    = 11;        // Shifter operand field
  localparam int unsigned OP2_LSB    = 0;
  localparam int unsigned OP2_W      = OP2_MSB - OP2_LSB + 1;

  // Sub-fields, relative to bit 0 of the instruction and of op2 alike
  localparam int unsigned ROT_MSB    = 11;        // Immediate rotate count
  localparam int unsigned ROT_LSB    = 8;
  localparam int unsigned IMM8_MSB   = 7;         // 8-bit immediate
  localparam int unsigned IMM8_LSB   = 0;
  localparam int unsigned SHAMT_MSB  = 11;        // Register shift amount
  localparam int unsigned SHAMT_LSB  = 7;
  localparam int unsigned SHAMT_W    = SHAMT_MSB - SHAMT_LSB + 1;
  localparam int unsigned SHTYPE_MSB = 6;         // Register shift type
  localparam int unsigned SHTYPE_LSB = 5;
  localparam int unsigned RM_MSB     = 3;         // Second source register
  localparam int unsigned RM_LSB     = 0;

  typedef enum logic [3:0] {
    AND = 4'd0,
    OR  = 4'd1,
    SUB = 4'd2,
    ADD = 4'd3                                    // Other codes yield zero
  } alu_op_e;

  typedef enum logic [1:0] {
    AM_ROT_IMM   = 2'd0,
    AM_REG       = 2'd1,
    AM_ZX_IMM    = 2'd2,
    AM_SHIFT_REG = 2'd3
  } am_e;

  typedef enum logic [1:0] {
    LSL = 2'd0,
    LSR = 2'd1,
    ASR = 2'd2,
    ROR = 2'd3
  } shift_e;

  typedef struct packed {
    logic n;                                      // Negative
    logic z;                                      // Zero
    logic c;                                      // Carry, or borrow on SUB
    logic v;                                      // Signed overflow
  } flags_t;

endpackage

`default_nettype wire

/* design/cpu_if.sv */
// Interfaces ex_bus_if (decode to execute) and wb_if (execute result bus) with modports
`default_nettype none

interface ex_bus_if import cpu_pkg::*; ();

  logic               valid;                      // Slot holds a real instruction
  alu_op_e            alu_op;
  logic               set_flags;                  // S bit
  reg_addr_t          rd;
  am_e                am;
  word_t              op_a;                       // Rn value after forwarding
  word_t              rm_val;                     // Rm value after forwarding
  logic [OP2_W-1:0]   op2;                        // Raw shifter operand field

  modport decode (
    output valid, alu_op, set_flags, rd, am, op_a, rm_val, op2
  );

  modport execute (
    input  valid, alu_op, set_flags, rd, am, op_a, rm_val, op2
  );

endinterface

interface wb_if import cpu_pkg::*; ();

  logic      valid;
  reg_addr_t rd;
  word_t     result;                              // Combinational ALU output
  logic      set_flags;
  flags_t    flags;                               // Candidate flags, used only with S

  modport execute (
    output valid, rd, result, set_flags, flags
  );

  // EX/WB register capture
  modport writeback (
    input  valid, rd, result, set_flags, flags
  );

  // Newest-result bypass into decode
  modport forward (
    input  valid, rd, result
  );

endinterface

`default_nettype wire

/* design/reg_file.sv */
// Sixteen-entry register file, two combinational read ports and one clocked write port
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t raddr_a,
  input  reg_addr_t raddr_b,
  output word_t     rdata_a,
  output word_t     rdata_b,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [NUM_REGS];                         // r0 to r15, no PC role

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;                            // Whole file starts at zero
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle writes are not visible here, decode forwards them instead
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

/* design/operand_shifter.sv */
// Second-operand generator for rotated immediate, register, zero-extended and shifted register
`default_nettype none

module operand_shifter import cpu_pkg::*; (
  input  am_e              am,
  input  word_t            rm_val,
  input  logic [OP2_W-1:0] op2,
  output word_t            operand_b
);

  logic [SHAMT_W-1:0] rot_amt;                    // Twice the rotate field
  logic [SHAMT_W-1:0] shamt;
  shift_e             shtype;
  word_t              imm8_ext;

  // Rotate right through a doubled word
  function automatic word_t ror_word(input word_t val, input logic [SHAMT_W-1:0] amt);
    logic [2*DATA_W-1:0] wide;
    wide = {val, val} >> amt;
    return wide[DATA_W-1:0];
  endfunction

  assign rot_amt  = {op2[ROT_MSB:ROT_LSB], 1'b0};
  assign shamt    = op2[SHAMT_MSB:SHAMT_LSB];
  assign shtype   = shift_e'(op2[SHTYPE_MSB:SHTYPE_LSB]);
  assign imm8_ext = word_t'(op2[IMM8_MSB:IMM8_LSB]);

  always_comb begin
    unique case (am)
      AM_ROT_IMM: operand_b = ror_word(imm8_ext, rot_amt);   // Can wrap into top byte
      AM_REG:     operand_b = rm_val;
      AM_ZX_IMM:  operand_b = word_t'(op2);                  // Full 12 bits, upper zero
      AM_SHIFT_REG: begin
        // Amount 0 leaves Rm as is for all four types
        unique case (shtype)
          LSL:     operand_b = rm_val << shamt;
          LSR:     operand_b = rm_val >> shamt;
          ASR:     operand_b = $signed(rm_val) >>> shamt;    // Sign bit fills from top
          ROR:     operand_b = ror_word(rm_val, shamt);
          default: operand_b = rm_val;
        endcase
      end
      default:    operand_b = rm_val;
    endcase
  end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// Decode stage with field split, operand read, two-level forwarding and ID/EX register
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  word_t     instr,
  input  logic      rf_we,                        // Write port of the instruction in WB
  input  reg_addr_t rf_waddr,
  input  word_t     rf_wdata,
  wb_if.forward     fwd,                          // Instruction now in execute
  ex_bus_if.decode  ex
);

  reg_addr_t rn;
  reg_addr_t rm;
  reg_addr_t rd;
  word_t     rf_rn;
  word_t     rf_rm;
  word_t     rn_val;
  word_t     rm_val;

  assign rn = instr[RN_MSB:RN_LSB];
  assign rm = instr[RM_MSB:RM_LSB];
  assign rd = instr[RD_MSB:RD_LSB];

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .raddr_a (rn),
    .raddr_b (rm),
    .rdata_a (rf_rn),
    .rdata_b (rf_rm),
    .we      (rf_we),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata)
  );

  // Newest copy of a register, execute beats write-back beats the file
  function automatic word_t pick_newest(input reg_addr_t addr, input word_t file_val);
    word_t val;
    if (fwd.valid && (fwd.rd == addr)) begin
      val = fwd.result;                           // One instruction ahead
    end else if (rf_we && (rf_waddr == addr)) begin
      val = rf_wdata;                             // Two ahead, file not yet written
    end else begin
      val = file_val;
    end
    return val;
  endfunction

  always_comb begin
    rn_val = pick_newest(rn, rf_rn);
    rm_val = pick_newest(rm, rf_rm);
  end

  // ID/EX register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex.valid     <= 1'b0;
      ex.alu_op    <= AND;
      ex.set_flags <= 1'b0;
      ex.rd        <= '0;
      ex.am        <= AM_ROT_IMM;
      ex.op_a      <= '0;
      ex.rm_val    <= '0;
      ex.op2       <= '0;
    end else begin
      ex.valid     <= instr_valid;                // Low input cycle becomes a bubble
      ex.alu_op    <= alu_op_e'(instr[OPC_MSB:OPC_LSB]);
      ex.set_flags <= instr[S_BIT];
      ex.rd        <= rd;
      ex.am        <= am_e'(instr[AM_MSB:AM_LSB]);
      ex.op_a      <= rn_val;
      ex.rm_val    <= rm_val;
      ex.op2       <= instr[OP2_MSB:OP2_LSB];
    end
  end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Execute stage with ALU, NZCV generation and combinational drive of the result bus
`default_nettype none

module execute_stage import cpu_pkg::*; (
  ex_bus_if.execute ex,
  wb_if.execute     wb
);

  word_t           operand_b;
  word_t           result;
  logic [DATA_W:0] sum;                           // Extra bit is the carry
  logic [DATA_W:0] diff;                          // Extra bit is the borrow
  logic            c;
  logic            v;
  logic            sign_a;
  logic            sign_b;
  flags_t          flags_new;

  operand_shifter u_operand_shifter (
    .am        (ex.am),
    .rm_val    (ex.rm_val),
    .op2       (ex.op2),
    .operand_b (operand_b)
  );

  assign sum    = {1'b0, ex.op_a} + {1'b0, operand_b};
  assign diff   = {1'b0, ex.op_a} - {1'b0, operand_b};
  assign sign_a = ex.op_a[DATA_W-1];
  assign sign_b = operand_b[DATA_W-1];

  always_comb begin
    c = 1'b0;                                     // Logic ops clear C and V
    v = 1'b0;
    case (ex.alu_op)
      AND: result = ex.op_a & operand_b;
      OR:  result = ex.op_a | operand_b;
      SUB: begin
        result = diff[DATA_W-1:0];
        c      = diff[DATA_W];                    // Set when A below B unsigned
        v      = (sign_a != sign_b) && (result[DATA_W-1] != sign_a);
      end
      ADD: begin
        result = sum[DATA_W-1:0];
        c      = sum[DATA_W];
        v      = (sign_a == sign_b) && (result[DATA_W-1] != sign_a);
      end
      default: result = '0;                       // Undefined opcode still writes Rd
    endcase
  end

  always_comb begin
    flags_new.n = result[DATA_W-1];
    flags_new.z = (result == '0);
    flags_new.c = c;
    flags_new.v = v;
  end

  // Result bus, also the execute-level bypass for decode
  assign wb.valid     = ex.valid;
  assign wb.rd        = ex.rd;
  assign wb.result    = result;
  assign wb.set_flags = ex.set_flags;
  assign wb.flags     = flags_new;

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
// Write-back stage with EX/WB register, flag register, register file write port and outputs
`default_nettype none

module writeback_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  wb_if.writeback   wb,
  output logic      rf_we,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_result,
  output flags_t    flags
);

  logic      valid_q;
  reg_addr_t rd_q;
  word_t     result_q;

  // EX/WB register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q  <= 1'b0;
      rd_q     <= '0;
      result_q <= '0;
    end else begin
      valid_q  <= wb.valid;
      rd_q     <= wb.rd;
      result_q <= wb.result;
    end
  end

  // NZCV, loaded in step with EX/WB
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (wb.valid && wb.set_flags) begin
      flags <= wb.flags;                          // S clear keeps old flags
    end
  end

  assign rf_we     = valid_q;                     // File updates one edge later
  assign rf_waddr  = rd_q;
  assign rf_wdata  = result_q;

  assign wb_valid  = valid_q;
  assign wb_rd     = rd_q;
  assign wb_result = result_q;

endmodule

`default_nettype wire

/* design/cpu_top.sv */
// Execute core top level connecting decode, execute and write-back stages
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  word_t     instr,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_result,
  output logic      flags_n,
  output logic      flags_z,
  output logic      flags_c,
  output logic      flags_v
);

  ex_bus_if  ex_bus ();                           // ID/EX contents
  wb_if      wb_bus ();                           // Execute result, same cycle

  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  flags_t    flags;

  decode_stage u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .fwd         (wb_bus.forward),
    .ex          (ex_bus.decode)
  );

  execute_stage u_execute (
    .ex (ex_bus.execute),
    .wb (wb_bus.execute)
  );

  writeback_stage u_writeback (
    .clk       (clk),
    .reset     (reset),
    .wb        (wb_bus.writeback),
    .rf_we     (rf_we),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_result (wb_result),
    .flags     (flags)
  );

  assign flags_n = flags.n;
  assign flags_z = flags.z;
  assign flags_c = flags.c;
  assign flags_v = flags.v;

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
// Testbench for cpu_top with clock, reset, stimulus and expected-value table, checker and watchdog
`default_nettype none

module cpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ENTRIES = 27;                  // Table rows incl. bubbles

  localparam logic [1:0] AM_ROT   = 2'd0;         // Addressing mode codes
  localparam logic [1:0] AM_RG    = 2'd1;
  localparam logic [1:0] AM_ZX    = 2'd2;
  localparam logic [1:0] AM_SHR   = 2'd3;
  localparam logic [3:0] OPC_AND  = 4'd0;
  localparam logic [3:0] OPC_OR   = 4'd1;
  localparam logic [3:0] OPC_SUB  = 4'd2;
  localparam logic [3:0] OPC_ADD  = 4'd3;
  localparam logic [1:0] SH_LSL   = 2'd0;
  localparam logic [1:0] SH_LSR   = 2'd1;
  localparam logic [1:0] SH_ASR   = 2'd2;
  localparam logic [1:0] SH_ROR   = 2'd3;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  logic [3:0]  wb_rd;
  logic [31:0] wb_result;
  logic        flags_n;
  logic        flags_z;
  logic        flags_c;
  logic        flags_v;

  logic        tab_valid  [N_ENTRIES];            // Stimulus columns
  logic [31:0] tab_instr  [N_ENTRIES];
  logic [3:0]  tab_rd     [N_ENTRIES];            // Expected columns
  logic [31:0] tab_result [N_ENTRIES];
  logic [3:0]  tab_nzcv   [N_ENTRIES];
  int          n_entries   = 0;
  int          valid_count = 0;
  int          seen_count  = 0;
  int          next_idx    = 0;                   // Next row the checker expects

  cpu_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_result   (wb_result),
    .flags_n     (flags_n),
    .flags_z     (flags_z),
    .flags_c     (flags_c),
    .flags_v     (flags_v)
  );

  always #4 clk = ~clk;                           // 8 ns period

  function automatic logic [31:0] encode_dp(input logic [1:0] am, input logic [3:0] opc,
                                            input logic s, input logic [3:0] rn,
                                            input logic [3:0] rd, input logic [11:0] op2);
    return {5'b0, am, opc, s, rn, rd, op2};       // Condition bits left at zero
  endfunction

  function automatic logic [11:0] rot_op2(input logic [3:0] rot, input logic [7:0] imm8);
    return {rot, imm8};
  endfunction

  function automatic logic [11:0] shift_op2(input logic [4:0] amt, input logic [1:0] typ,
                                            input logic [3:0] rm);
    return {amt, typ, 1'b0, rm};
  endfunction

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic add_entry(input logic v, input logic [31:0] ins, input logic [3:0] rd,
                           input logic [31:0] res, input logic [3:0] nzcv);
    tab_valid[n_entries]  = v;
    tab_instr[n_entries]  = ins;
    tab_rd[n_entries]     = rd;
    tab_result[n_entries] = res;
    tab_nzcv[n_entries]   = nzcv;
    n_entries++;
    if (v) valid_count++;
  endtask

  task automatic build_table();
    // Registers start at zero, flags are NZCV
    add_entry(1, encode_dp(AM_ZX, OPC_ADD, 0, 0, 1, 12'h123), 1, 32'h0000_0123, 4'b0000);
    add_entry(1, encode_dp(AM_ZX, OPC_ADD, 1, 0, 2, 12'hFFF), 2, 32'h0000_0FFF, 4'b0000);
    add_entry(1, encode_dp(AM_ZX, OPC_AND, 0, 2, 3, 12'h0F0), 3, 32'h0000_00F0, 4'b0000);
    add_entry(1, encode_dp(AM_ROT, OPC_OR, 1, 3, 4, rot_op2(4, 8'hAB)),
              4, 32'hAB00_00F0, 4'b1000);         // Imm8 lands in top byte
    add_entry(1, encode_dp(AM_ZX, OPC_SUB, 1, 4, 5, 12'h0F0), 5, 32'hAB00_0000, 4'b1000);
    add_entry(1, encode_dp(AM_ROT, OPC_ADD, 0, 0, 6, rot_op2(1, 8'h07)),
              6, 32'hC000_0001, 4'b1000);         // Rotate wraps low bits, S clear holds
    add_entry(1, encode_dp(AM_ROT, OPC_AND, 1, 6, 7, rot_op2(0, 8'hFF)),
              7, 32'h0000_0001, 4'b0000);
    add_entry(1, encode_dp(AM_RG, OPC_SUB, 1, 1, 8, 12'h002), 8, 32'hFFFF_F124, 4'b1010);
    add_entry(1, encode_dp(AM_RG, OPC_ADD, 0, 8, 9, 12'h005), 9, 32'hAAFF_F124, 4'b1010);
    add_entry(1, encode_dp(AM_SHR, OPC_ADD, 1, 8, 10, shift_op2(4, SH_LSL, 1)),
              10, 32'h0000_0354, 4'b0010);        // r8 two ahead, carry out
    add_entry(1, encode_dp(AM_SHR, OPC_ADD, 0, 0, 11, shift_op2(8, SH_LSR, 4)),
              11, 32'h00AB_0000, 4'b0010);
    add_entry(1, encode_dp(AM_SHR, OPC_ADD, 0, 0, 12, shift_op2(4, SH_ASR, 4)),
              12, 32'hFAB0_000F, 4'b0010);        // Sign fill
    add_entry(1, encode_dp(AM_SHR, OPC_ADD, 0, 0, 13, shift_op2(12, SH_ROR, 4)),
              13, 32'h0F0A_B000, 4'b0010);
    add_entry(1, encode_dp(AM_SHR, OPC_ADD, 0, 0, 14, shift_op2(0, SH_ASR, 4)),
              14, 32'hAB00_00F0, 4'b0010);        // Amount 0 passes Rm
    add_entry(1, encode_dp(AM_ZX, OPC_OR, 0, 0, 15, 12'h800), 15, 32'h0000_0800, 4'b0010);
    add_entry(0, encode_dp(AM_ZX, OPC_AND, 1, 0, 15, 12'h000), 0, 32'h0, 4'b0000);
    add_entry(0, encode_dp(AM_ZX, OPC_AND, 1, 0, 15, 12'h000), 0, 32'h0, 4'b0000);
    add_entry(1, encode_dp(AM_ZX, OPC_SUB, 0, 15, 1, 12'h001),
              1, 32'h0000_07FF, 4'b0010);         // r15 read from the file
    add_entry(1, encode_dp(AM_RG, OPC_SUB, 1, 1, 2, 12'h001), 2, 32'h0000_0000, 4'b0100);
    add_entry(1, encode_dp(AM_ROT, OPC_OR, 0, 0, 3, rot_op2(1, 8'h02)),
              3, 32'h8000_0000, 4'b0100);
    add_entry(1, encode_dp(AM_ROT, OPC_SUB, 1, 3, 3, rot_op2(0, 8'h01)),
              3, 32'h7FFF_FFFF, 4'b0001);         // Signed overflow on SUB
    add_entry(1, encode_dp(AM_ZX, OPC_ADD, 1, 3, 4, 12'h001),
              4, 32'h8000_0000, 4'b1001);         // Execute copy of r3 beats write-back
    add_entry(1, encode_dp(AM_RG, OPC_ADD, 1, 4, 5, 12'h004),
              5, 32'h0000_0000, 4'b0111);         // Z, C and V together
    add_entry(1, encode_dp(AM_RG, OPC_OR, 0, 5, 6, 12'h003), 6, 32'h7FFF_FFFF, 4'b0111);
    add_entry(1, encode_dp(AM_RG, 4'd5, 0, 6, 7, 12'h006),
              7, 32'h0000_0000, 4'b0111);         // Undefined opcode gives zero
    add_entry(1, encode_dp(AM_ROT, OPC_AND, 1, 6, 8, rot_op2(0, 8'hFF)),
              8, 32'h0000_00FF, 4'b0000);         // Logic op clears C and V
    add_entry(0, encode_dp(AM_ZX, OPC_ADD, 1, 0, 9, 12'h001), 0, 32'h0, 4'b0000);
  endtask

  // Result checker, samples away from the rising edge
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      while (next_idx < n_entries && !tab_valid[next_idx]) next_idx++;
      if (next_idx >= n_entries) begin
        stop_on_error("wb_valid asserted with no valid instruction left to retire");
      end else begin
        check_value("wb_rd", 32'(wb_rd), 32'(tab_rd[next_idx]));
        check_value("wb_result", wb_result, tab_result[next_idx]);
        check_value("flags_nzcv", 32'({flags_n, flags_z, flags_c, flags_v}),
                    32'(tab_nzcv[next_idx]));
        next_idx++;
        seen_count++;
      end
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    build_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("wb_valid", 32'(wb_valid), 32'h0);                    // Quiet after reset
    check_value("flags_nzcv", 32'({flags_n, flags_z, flags_c, flags_v}), 32'h0);
    for (int i = 0; i < n_entries; i++) begin
      @(posedge clk);
      instr_valid <= tab_valid[i];
      instr       <= tab_instr[i];
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= '0;
    repeat (4) @(posedge clk);                    // Two-edge latency plus room for stray pulses
    if (seen_count == valid_count) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("Saw %0d results, expected %0d", seen_count, valid_count));
    end
  end

  initial begin
    #((N_ENTRIES + 20) * 8);
    stop_on_error("Timeout: the expected results did not all arrive in time");
  end

endmodule

`default_nettype wire

/* verilog.f */
design/cpu_pkg.sv
design/cpu_if.sv
design/reg_file.sv
design/operand_shifter.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_top.sv
bench/cpu_tb.sv
